// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - common/ex_pkg.sv
  - common/ex_stage_if.sv
  - common/div_if.sv
  - verilog/ex_pipe_reg.sv
  - verilog/ex_fast_unit.sv
  - divider/div_radix2.sv
  - verilog/ex_result_mem.sv
  - verilog/ex_top.sv
  - target: test
    files:
      - testbench/tb_ex_top.sv

// ==== common/div_if.sv ====
`timescale 1ns/1ps

interface div_if import ex_pkg::*; ();

    logic            start;       // one cycle pulse
    logic            is_signed;
    logic [xlen-1:0] dividend;
    logic [xlen-1:0] divisor;
    logic            done;        // one cycle pulse
    logic [xlen-1:0] quotient;
    logic [xlen-1:0] remainder;

    modport requester (
        output start, is_signed, dividend, divisor,
        input  done
    );

    modport divider (
        input  start, is_signed, dividend, divisor,
        output done, quotient, remainder
    );

    // result side only needs the values
    modport reader (
        input quotient, remainder
    );

endinterface

// ==== common/ex_pkg.sv ====
package ex_pkg;

    localparam int xlen       = 32;
    localparam int regaddr_w  = 5;
    localparam int div_cycles = 32;                  // one quotient bit per cycle
    localparam int div_cnt_w  = $clog2(div_cycles);

    // execute operations, decoded upstream
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_mul_w,
        op_mulh_w,
        op_mulh_wu,
        op_div_w,
        op_mod_w,
        op_div_wu,
        op_mod_wu
    } ex_op_e;

    typedef enum logic [2:0] {
        mem_none,
        mem_ld_w,
        mem_st_b,
        mem_st_h,
        mem_st_w
    } mem_op_e;

    // ops that go through the iterative divider
    function automatic logic is_div_op(input ex_op_e op);
        return op inside {op_div_w, op_mod_w, op_div_wu, op_mod_wu};
    endfunction

    function automatic logic is_signed_div(input ex_op_e op);
        return op inside {op_div_w, op_mod_w};
    endfunction

endpackage

// ==== common/ex_stage_if.sv ====
`timescale 1ns/1ps

// latched instruction, pipeline register to the working units
interface ex_stage_if import ex_pkg::*; ();

    logic                 valid;
    ex_op_e               op;
    mem_op_e              mem_op;
    logic [xlen-1:0]      src1;
    logic [xlen-1:0]      src2;
    logic [xlen-1:0]      rkd_value;   // store data
    logic                 rf_we;
    logic [regaddr_w-1:0] rf_waddr;
    logic [xlen-1:0]      pc;

    modport producer (
        output valid, op, mem_op, src1, src2, rkd_value, rf_we, rf_waddr, pc
    );

    modport consumer (
        input valid, op, mem_op, src1, src2, rkd_value, rf_we, rf_waddr, pc
    );

endinterface

// ==== divider/div_radix2.sv ====
`timescale 1ns/1ps

module div_radix2 import ex_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    div_if.divider   div
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix
    } div_state_e;

    div_state_e           state;
    logic [div_cnt_w-1:0] cnt;
    logic [xlen-1:0]      quo;      // dividend shifts out, quotient shifts in
    logic [xlen-1:0]      rem;
    logic [xlen-1:0]      dsr;      // divisor magnitude
    logic                 q_neg;
    logic                 r_neg;
    logic                 a_neg;
    logic                 b_neg;
    logic [xlen-1:0]      a_mag;
    logic [xlen-1:0]      b_mag;
    logic [xlen:0]        trial;
    logic [xlen:0]        sub;

    assign a_neg = div.is_signed & div.dividend[xlen-1];
    assign b_neg = div.is_signed & div.divisor[xlen-1];
    assign a_mag = a_neg ? -div.dividend : div.dividend;
    assign b_mag = b_neg ? -div.divisor : div.divisor;

    // one restoring step
    assign trial = {rem, quo[xlen-1]};
    assign sub   = trial - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (div.start) state <= st_run;  // start ignored when busy
                st_run:  if (cnt == '0) state <= st_fix;
                st_fix:  state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && div.start) begin
            quo   <= a_mag;
            rem   <= '0;
            dsr   <= b_mag;
            cnt   <= div_cnt_w'(div_cycles - 1);
            // zero divisor keeps the all ones quotient unsigned
            q_neg <= (a_neg ^ b_neg) & (div.divisor != '0);
            r_neg <= a_neg;                // remainder follows the dividend
        end else if (state == st_run) begin
            cnt <= cnt - 1'b1;
            quo <= {quo[xlen-2:0], ~sub[xlen]};
            rem <= sub[xlen] ? trial[xlen-1:0] : sub[xlen-1:0];
        end
    end

    // sign fix on the magnitudes
    // min / -1 wraps back to the most negative value with rem 0
    assign div.quotient  = q_neg ? -quo : quo;
    assign div.remainder = r_neg ? -rem : rem;
    assign div.done      = (state == st_fix);

endmodule

// ==== tb.f ====
common/ex_pkg.sv
common/ex_stage_if.sv
common/div_if.sv
verilog/ex_pipe_reg.sv
verilog/ex_fast_unit.sv
divider/div_radix2.sv
verilog/ex_result_mem.sv
verilog/ex_top.sv
testbench/tb_ex_top.sv

// ==== testbench/tb_ex_top.sv ====
`timescale 1ns/1ps

module tb_ex_top import ex_pkg::*; ();

    localparam int n_directed = 125 + 9 + 8 + 16;
    localparam int n_random   = 300;
    localparam int cycle_limit = (n_directed + n_random) * (div_cycles + 4) + 4 + 1000;

    typedef struct packed {
        ex_op_e               op;
        mem_op_e              mem_op;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      result;
        logic                 rf_we;
        logic [regaddr_w-1:0] rf_waddr;
        logic [xlen-1:0]      addr;
        logic [xlen-1:0]      wdata;
        logic [3:0]           we;
    } expect_t;

    logic                 clk;
    logic                 resetn;
    logic                 in_valid;
    ex_op_e               in_op;
    mem_op_e              in_mem_op;
    logic [xlen-1:0]      in_src1;
    logic [xlen-1:0]      in_src2;
    logic [xlen-1:0]      in_rkd_value;
    logic                 in_rf_we;
    logic [regaddr_w-1:0] in_rf_waddr;
    logic [xlen-1:0]      in_pc;
    logic                 ms_allowin;
    logic                 in_allowin;
    logic                 out_valid;
    logic [xlen-1:0]      out_pc;
    logic [xlen-1:0]      out_result;
    logic                 out_rf_we;
    logic                 out_res_from_mem;
    logic [regaddr_w-1:0] out_rf_waddr;
    logic                 data_sram_en;
    logic [3:0]           data_sram_we;
    logic [xlen-1:0]      data_sram_addr;
    logic [xlen-1:0]      data_sram_wdata;

    integer          seed;
    string           test_name;
    expect_t         exp_q[$];       // at most one entry, mirrors the stage
    int              n_sent;
    int              n_retired;
    int              div_wait;
    int              cycles;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] edge_vals [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1};

    ex_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
        if (exp !== act) begin
            $display("error: %s %s expected %h actual %h", test_name, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s (%s)", msg, test_name);
        $display("TEST FAILED");
        $fatal(1, "protocol failure");
    endtask

    function automatic logic [xlen-1:0] model_result(ex_op_e op, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
        logic [2*xlen-1:0] ps;
        logic [2*xlen-1:0] pu;
        logic              is_div;
        ps = {{xlen{a[xlen-1]}}, a} * {{xlen{b[xlen-1]}}, b};   // low 64 bits of signed product
        pu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
        is_div = (op == op_div_w) || (op == op_div_wu);
        case (op)
            op_add:     return a + b;
            op_sub:     return a - b;
            op_slt:     return {31'b0, $signed(a) < $signed(b)};
            op_sltu:    return {31'b0, a < b};
            op_and:     return a & b;
            op_or:      return a | b;
            op_nor:     return ~(a | b);
            op_xor:     return a ^ b;
            op_sll:     return a << b[4:0];
            op_srl:     return a >> b[4:0];
            op_sra:     return $signed(a) >>> b[4:0];
            op_lui:     return b;
            op_mul_w:   return ps[xlen-1:0];
            op_mulh_w:  return ps[2*xlen-1:xlen];
            op_mulh_wu: return pu[2*xlen-1:xlen];
            default: begin
                if (b == 0) begin
                    return is_div ? 32'hffff_ffff : a;
                end
                if (op == op_div_wu) return a / b;
                if (op == op_mod_wu) return a % b;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                    return is_div ? a : 32'h0;   // signed overflow
                end
                return is_div ? $signed(a) / $signed(b) : $signed(a) % $signed(b);
            end
        endcase
    endfunction

    function automatic expect_t predict(ex_op_e op, mem_op_e mop, logic [xlen-1:0] a,
                                        logic [xlen-1:0] b, logic [xlen-1:0] rkd, logic we,
                                        logic [regaddr_w-1:0] waddr, logic [xlen-1:0] pc);
        expect_t         e;
        logic [xlen-1:0] sum;
        sum        = a + b;
        e.op       = op;
        e.mem_op   = mop;
        e.pc       = pc;
        e.rf_we    = we;
        e.rf_waddr = waddr;
        e.result   = model_result(op, a, b);
        e.addr     = {sum[xlen-1:2], 2'b00};
        e.wdata    = rkd;
        e.we       = 4'b0000;
        case (mop)
            mem_st_b: begin
                e.we    = 4'b0001 << sum[1:0];
                e.wdata = {4{rkd[7:0]}};
            end
            mem_st_h: begin
                e.we    = sum[1] ? 4'b1100 : 4'b0011;
                e.wdata = {2{rkd[15:0]}};
            end
            mem_st_w: e.we = 4'b1111;
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [xlen-1:0] pick_operand();
        if ({$random(seed)} % 4 == 0) begin
            return edge_vals[{$random(seed)} % 5];
        end
        return $random(seed);
    endfunction

    // one clock with a fresh random back-pressure level
    task automatic step();
        @(posedge clk);
        ms_allowin <= ({$random(seed)} % 4 != 0);
    endtask

    task automatic send(input ex_op_e op, input mem_op_e mop, input logic [xlen-1:0] a,
                        input logic [xlen-1:0] b, input logic [xlen-1:0] rkd);
        logic taken;
        logic is_store;
        taken    = 1'b0;
        is_store = (mop == mem_st_b) || (mop == mem_st_h) || (mop == mem_st_w);
        in_valid     <= 1'b1;
        in_op        <= op;
        in_mem_op    <= mop;
        in_src1      <= a;
        in_src2      <= b;
        in_rkd_value <= rkd;
        in_rf_we     <= is_store ? 1'b0 : 1'($random(seed));
        in_rf_waddr  <= regaddr_w'($random(seed));
        in_pc        <= pc_next;
        pc_next = pc_next + 4;
        while (!taken) begin
            @(negedge clk);
            taken = in_allowin;     // accepted on the coming edge
            step();
        end
        n_sent++;
        if ({$random(seed)} % 4 == 0) begin
            in_valid <= 1'b0;
            repeat (1 + {$random(seed)} % 2) step();
        end
    endtask

    // reference model and output checks, sampled mid-cycle
    always @(negedge clk) begin
        expect_t head;
        if (resetn) begin
            check("in_allowin", exp_q.size() == 0 || (out_valid && ms_allowin), in_allowin);
            if (out_valid) begin
                if (exp_q.size() == 0) fail_now("out_valid high with an empty stage");
                head = exp_q[0];
                if (head.op inside {op_div_w, op_mod_w, op_div_wu, op_mod_wu}
                    && div_wait < div_cycles) begin
                    fail_now("divide result valid before the divider could finish");
                end
                check("out_pc", head.pc, out_pc);
                check("out_result", head.result, out_result);
                check("out_rf_we", head.rf_we, out_rf_we);
                check("out_rf_waddr", head.rf_waddr, out_rf_waddr);
                check("out_res_from_mem", head.mem_op == mem_ld_w, out_res_from_mem);
                check("data_sram_en", head.mem_op != mem_none, data_sram_en);
                check("data_sram_we", head.we, data_sram_we);
                if (head.mem_op != mem_none) check("data_sram_addr", head.addr, data_sram_addr);
                if (head.we != 4'b0000) check("data_sram_wdata", head.wdata, data_sram_wdata);
                if (ms_allowin) begin
                    void'(exp_q.pop_front());
                    n_retired++;
                    div_wait = 0;
                end
            end else if (exp_q.size() != 0) begin
                if (!(exp_q[0].op inside {op_div_w, op_mod_w, op_div_wu, op_mod_wu})) begin
                    fail_now("single cycle instruction not ready");
                end
                div_wait++;
            end
            if (in_valid && in_allowin) begin
                exp_q.push_back(predict(in_op, in_mem_op, in_src1, in_src2, in_rkd_value,
                                        in_rf_we, in_rf_waddr, in_pc));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d retired", cycles, n_retired, n_sent);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        ex_op_e          op;
        mem_op_e         mop;
        ex_op_e          edge_ops [5];
        logic [xlen-1:0] mul_a [3];
        logic [xlen-1:0] mul_b [3];
        ex_op_e          mul_ops [3];
        mem_op_e         mem_ops [4];
        int              i;
        int              j;
        int              k;
        seed = 32'hea21a776;
        edge_ops = '{op_slt, op_sltu, op_sll, op_srl, op_sra};
        mul_a    = '{32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
        mul_b    = '{32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff};
        mul_ops  = '{op_mul_w, op_mulh_w, op_mulh_wu};
        mem_ops  = '{mem_ld_w, mem_st_b, mem_st_h, mem_st_w};
        resetn = 1'b0;
        in_valid = 1'b0;
        in_op = op_add;
        in_mem_op = mem_none;
        in_src1 = '0;
        in_src2 = '0;
        in_rkd_value = '0;
        in_rf_we = 1'b0;
        in_rf_waddr = '0;
        in_pc = '0;
        ms_allowin = 1'b1;
        n_sent = 0;
        n_retired = 0;
        div_wait = 0;
        cycles = 0;
        pc_next = 32'h1c00_0000;
        test_name = "reset";
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check("out_valid", 1'b0, out_valid);
        check("data_sram_en", 1'b0, data_sram_en);
        check("data_sram_we", 4'b0000, data_sram_we);
        check("in_allowin", 1'b1, in_allowin);
        @(posedge clk);

        test_name = "alu edges";
        for (k = 0; k < 5; k++) begin
            for (i = 0; i < 5; i++) begin
                for (j = 0; j < 5; j++) begin
                    send(edge_ops[k], mem_none, edge_vals[i], edge_vals[j], '0);
                end
            end
        end

        test_name = "multiply";
        for (k = 0; k < 3; k++) begin
            for (i = 0; i < 3; i++) begin
                send(mul_ops[k], mem_none, mul_a[i], mul_b[i], '0);
            end
        end

        test_name = "divide";
        send(op_div_w, mem_none, 32'h8000_0000, 32'hffff_ffff, '0);
        send(op_mod_w, mem_none, 32'h8000_0000, 32'hffff_ffff, '0);
        send(op_div_w, mem_none, 32'hffff_fff9, 32'h2, '0);     // -7 / 2
        send(op_mod_w, mem_none, 32'hffff_fff9, 32'h2, '0);
        send(op_div_wu, mem_none, 32'h4d2, 32'h0, '0);
        send(op_mod_wu, mem_none, 32'h4d2, 32'h0, '0);
        send(op_div_w, mem_none, 32'hffff_fff9, 32'h0, '0);
        send(op_mod_w, mem_none, 32'hffff_fff9, 32'h0, '0);

        test_name = "memory";
        for (i = 0; i < 4; i++) begin
            for (k = 0; k < 4; k++) begin
                send(op_add, mem_ops[k], $random(seed) & 32'hffff_fffc, i, $random(seed));
            end
        end

        test_name = "random";
        for (i = 0; i < n_random; i++) begin
            if ({$random(seed)} % 8 == 0) begin
                mop = mem_ops[{$random(seed)} % 4];
                op  = op_add;
            end else begin
                mop = mem_none;
                op  = ex_op_e'(5'({$random(seed)} % 19));
            end
            send(op, mop, pick_operand(), pick_operand(), $random(seed));
        end

        // drain whatever is still in the stage
        in_valid <= 1'b0;
        while (exp_q.size() != 0) step();
        repeat (4) step();
        if (n_retired != n_sent) begin
            $display("instruction count differs, accepted %0d retired %0d", n_sent, n_retired);
            $display("TEST FAILED");
            $fatal(1, "count mismatch");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog/ex_fast_unit.sv ====
`timescale 1ns/1ps

module ex_fast_unit import ex_pkg::*; (
    ex_stage_if.consumer     stage,
    output logic [xlen-1:0]  fast_result
);

    logic signed [2*xlen-1:0] prod_s;
    logic        [2*xlen-1:0] prod_u;
    logic        [4:0]        shamt;
    logic        [xlen-1:0]   sum;
    logic        [xlen-1:0]   diff;
    logic                     lt_s;
    logic                     lt_u;

    // both products in full width, the op picks a word
    assign prod_s = $signed(stage.src1) * $signed(stage.src2);
    assign prod_u = stage.src1 * stage.src2;

    assign shamt = stage.src2[4:0];
    assign sum   = stage.src1 + stage.src2;
    assign diff  = stage.src1 - stage.src2;
    assign lt_s  = $signed(stage.src1) < $signed(stage.src2);
    assign lt_u  = stage.src1 < stage.src2;

    always_comb begin
        case (stage.op)
            op_add: begin
                fast_result = sum;      // also the load/store address
            end
            op_sub: begin
                fast_result = diff;
            end
            op_slt: begin
                fast_result = {{(xlen-1){1'b0}}, lt_s};
            end
            op_sltu: begin
                fast_result = {{(xlen-1){1'b0}}, lt_u};
            end
            op_and: begin
                fast_result = stage.src1 & stage.src2;
            end
            op_or: begin
                fast_result = stage.src1 | stage.src2;
            end
            op_nor: begin
                fast_result = ~(stage.src1 | stage.src2);
            end
            op_xor: begin
                fast_result = stage.src1 ^ stage.src2;
            end
            op_sll: begin
                fast_result = stage.src1 << shamt;
            end
            op_srl: begin
                fast_result = stage.src1 >> shamt;
            end
            op_sra: begin
                fast_result = $signed(stage.src1) >>> shamt;
            end
            op_lui: begin
                fast_result = stage.src2;   // immediate already shifted by decode
            end
            op_mul_w: begin
                fast_result = prod_s[xlen-1:0];
            end
            op_mulh_w: begin
                fast_result = prod_s[2*xlen-1:xlen];
            end
            op_mulh_wu: begin
                fast_result = prod_u[2*xlen-1:xlen];
            end
            default: begin
                fast_result = '0;       // divides come from the divider
            end
        endcase
    end

endmodule

// ==== verilog/ex_pipe_reg.sv ====
`timescale 1ns/1ps

module ex_pipe_reg import ex_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    input  ex_op_e               in_op,
    input  mem_op_e              in_mem_op,
    input  logic [xlen-1:0]      in_src1,
    input  logic [xlen-1:0]      in_src2,
    input  logic [xlen-1:0]      in_rkd_value,
    input  logic                 in_rf_we,
    input  logic [regaddr_w-1:0] in_rf_waddr,
    input  logic [xlen-1:0]      in_pc,
    input  logic                 ms_allowin,
    output logic                 in_allowin,
    output logic                 out_valid,
    ex_stage_if.producer         stage,
    div_if.requester             div
);

    logic ready_go;
    logic accept;
    logic leave;
    logic start_r;
    logic div_done_r;   // sticky, divider finished for the held instruction

    // long ops wait for the divider, everything else goes at once
    assign ready_go   = ~is_div_op(stage.op) | div_done_r;
    assign out_valid  = stage.valid & ready_go;
    assign leave      = out_valid & ms_allowin;
    assign in_allowin = ~stage.valid | leave;
    assign accept     = in_valid & in_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage.valid <= 1'b0;
        end else if (in_allowin) begin
            stage.valid <= in_valid;
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (accept) begin
            stage.op        <= in_op;
            stage.mem_op    <= in_mem_op;
            stage.src1      <= in_src1;
            stage.src2      <= in_src2;
            stage.rkd_value <= in_rkd_value;
            stage.rf_we     <= in_rf_we;
            stage.rf_waddr  <= in_rf_waddr;
            stage.pc        <= in_pc;
        end
    end

    // single start pulse in the first cycle of a divide
    always_ff @(posedge clk) begin
        if (!resetn) begin
            start_r <= 1'b0;
        end else begin
            start_r <= accept & is_div_op(in_op);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_done_r <= 1'b0;
        end else if (leave) begin
            div_done_r <= 1'b0;     // next instruction starts clean
        end else if (div.done) begin
            div_done_r <= 1'b1;
        end
    end

    assign div.start     = start_r;
    assign div.is_signed = is_signed_div(stage.op);
    assign div.dividend  = stage.src1;
    assign div.divisor   = stage.src2;

endmodule

// ==== verilog/ex_result_mem.sv ====
`timescale 1ns/1ps

module ex_result_mem import ex_pkg::*; (
    ex_stage_if.consumer         stage,
    div_if.reader                div,
    input  logic [xlen-1:0]      fast_result,
    output logic [xlen-1:0]      out_pc,
    output logic [xlen-1:0]      out_result,
    output logic                 out_rf_we,
    output logic                 out_res_from_mem,
    output logic [regaddr_w-1:0] out_rf_waddr,
    output logic                 data_sram_en,
    output logic [3:0]           data_sram_we,
    output logic [xlen-1:0]      data_sram_addr,
    output logic [xlen-1:0]      data_sram_wdata
);

    logic [1:0] addr_lo;
    logic [3:0] st_mask;

    assign addr_lo = fast_result[1:0];

    always_comb begin
        case (stage.op)
            op_div_w, op_div_wu: out_result = div.quotient;
            op_mod_w, op_mod_wu: out_result = div.remainder;
            default:             out_result = fast_result;
        endcase
    end

    // byte lanes from the address offset
    always_comb begin
        case (stage.mem_op)
            mem_st_b: st_mask = 4'b0001 << addr_lo;
            mem_st_h: st_mask = 4'b0011 << {addr_lo[1], 1'b0};
            mem_st_w: st_mask = 4'b1111;
            default:  st_mask = 4'b0000;    // loads and non memory ops
        endcase
    end

    always_comb begin
        case (stage.mem_op)
            mem_st_b: data_sram_wdata = {4{stage.rkd_value[7:0]}};
            mem_st_h: data_sram_wdata = {2{stage.rkd_value[15:0]}};
            default:  data_sram_wdata = stage.rkd_value;
        endcase
    end

    assign data_sram_addr = {fast_result[xlen-1:2], 2'b00};   // word aligned
    assign data_sram_en   = (stage.mem_op != mem_none) & stage.valid;
    assign data_sram_we   = st_mask & {4{stage.valid}};

    // write-back info for the memory stage
    assign out_pc           = stage.pc;
    assign out_rf_we        = stage.rf_we & stage.valid;
    assign out_res_from_mem = (stage.mem_op == mem_ld_w) & stage.valid;
    assign out_rf_waddr     = stage.rf_waddr;

endmodule

// ==== verilog/ex_top.sv ====
`timescale 1ns/1ps

module ex_top import ex_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    input  ex_op_e               in_op,
    input  mem_op_e              in_mem_op,
    input  logic [xlen-1:0]      in_src1,
    input  logic [xlen-1:0]      in_src2,
    input  logic [xlen-1:0]      in_rkd_value,
    input  logic                 in_rf_we,
    input  logic [regaddr_w-1:0] in_rf_waddr,
    input  logic [xlen-1:0]      in_pc,
    input  logic                 ms_allowin,
    output logic                 in_allowin,
    output logic                 out_valid,
    output logic [xlen-1:0]      out_pc,
    output logic [xlen-1:0]      out_result,
    output logic                 out_rf_we,
    output logic                 out_res_from_mem,
    output logic [regaddr_w-1:0] out_rf_waddr,
    output logic                 data_sram_en,
    output logic [3:0]           data_sram_we,
    output logic [xlen-1:0]      data_sram_addr,
    output logic [xlen-1:0]      data_sram_wdata
);

    ex_stage_if      stage_bus ();
    div_if           div_bus ();
    logic [xlen-1:0] fast_result;

    ex_pipe_reg u_pipe_reg (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_mem_op    (in_mem_op),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .in_rkd_value (in_rkd_value),
        .in_rf_we     (in_rf_we),
        .in_rf_waddr  (in_rf_waddr),
        .in_pc        (in_pc),
        .ms_allowin   (ms_allowin),
        .in_allowin   (in_allowin),
        .out_valid    (out_valid),
        .stage        (stage_bus.producer),
        .div          (div_bus.requester)
    );

    // single cycle ops and the divider run side by side
    ex_fast_unit u_fast_unit (
        .stage       (stage_bus.consumer),
        .fast_result (fast_result)
    );

    div_radix2 u_div (
        .clk    (clk),
        .resetn (resetn),
        .div    (div_bus.divider)
    );

    ex_result_mem u_result_mem (
        .stage            (stage_bus.consumer),
        .div              (div_bus.reader),
        .fast_result      (fast_result),
        .out_pc           (out_pc),
        .out_result       (out_result),
        .out_rf_we        (out_rf_we),
        .out_res_from_mem (out_res_from_mem),
        .out_rf_waddr     (out_rf_waddr),
        .data_sram_en     (data_sram_en),
        .data_sram_we     (data_sram_we),
        .data_sram_addr   (data_sram_addr),
        .data_sram_wdata  (data_sram_wdata)
    );

endmodule
